// File: sim.f
rtl/p_hit_pkg.sv
rtl/fifo_array.sv
rtl/p_hit_div.sv
rtl/p_hit_scale_add.sv
rtl/p_hit.sv
verif/p_hit_tb.sv

// File: Makefile
# Verilator flow for the ray and plane hit point testbench

VERILATOR ?= verilator
TOP       ?= p_hit_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal
FAIL_MSG  ?= TEST FAIL
PASS_MSG  ?= TEST PASS

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	@./$(BIN) > $(LOG) 2>&1; echo "simulator exit status $$?" >> $(LOG); cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/p_hit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module p_hit_tb;

    import p_hit_pkg::*;

    // int and longint reference model needs 32 bit words
    localparam int D_BITS     = D_BITS_DEF;
    localparam int Q_BITS     = Q_BITS_DEF;
    localparam int M_BITS     = M_BITS_DEF;
    localparam int FIFO_DEPTH = FIFO_DEPTH_DEF;
    localparam int K          = 1 << Q_BITS;
    localparam int N_TAB      = 7;
    localparam int N_BURST    = 2 * FIFO_DEPTH;
    localparam int N_RAND     = 40;
    localparam int MAX_REC    = N_TAB + N_BURST + N_RAND;
    localparam int TIMEOUT    = MAX_REC * (D_BITS + Q_BITS + 8) + 200;

    logic clock;
    logic rst_n;
    logic in_wr_en;
    logic out_rd_en;
    logic in_full;
    logic out_empty;
    logic signed [D_BITS-1:0] n_in_x, n_in_y, n_in_z;
    logic signed [D_BITS-1:0] v0_in_x, v0_in_y, v0_in_z;
    logic signed [D_BITS-1:0] v1_in_x, v1_in_y, v1_in_z;
    logic signed [D_BITS-1:0] v2_in_x, v2_in_y, v2_in_z;
    logic signed [D_BITS-1:0] o_x, o_y, o_z;
    logic signed [D_BITS-1:0] d_x, d_y, d_z;
    logic [M_BITS-1:0]        triangle_id_in;
    logic signed [D_BITS-1:0] p_x, p_y, p_z;
    logic signed [D_BITS-1:0] n_out_x, n_out_y, n_out_z;
    logic signed [D_BITS-1:0] v0_out_x, v0_out_y, v0_out_z;
    logic signed [D_BITS-1:0] v1_out_x, v1_out_y, v1_out_z;
    logic signed [D_BITS-1:0] v2_out_x, v2_out_y, v2_out_z;
    logic [M_BITS-1:0]        triangle_id_out;

    logic [31:0] lfsr;
    int          err_cnt = 0;
    int          check_cnt = 0;
    int          cycles = 0;
    int          wr_idx = 0;
    int          rd_idx = 0;
    int          pop_cnt = 0;

    // columns n xyz, v0 xyz, v1 xyz, v2 xyz, o xyz, d xyz, id, expected p xyz
    int rec [MAX_REC][22];

    // hand worked cases in raw Q16
    int tab [N_TAB][22] = '{
        // plane z = 5 with integer t
        '{0, 0, K,  0, 0, 5*K,  K, 0, 5*K,  0, K, 5*K,
          K, 2*K, 0,  0, 0, K,  32'h0000_0011,  K, 2*K, 5*K},
        // plane x = 3 with a scaled normal
        '{2*K, 0, 0,  3*K, 0, 0,  3*K, K, 0,  3*K, 0, K,
          0, K, K,  K, K, 0,  32'h0000_0022,  3*K, 4*K, K},
        // t = 1/3 truncated toward zero
        '{0, K, 0,  0, K, 0,  K, K, 0,  0, K, K,
          0, 0, 0,  K, 3*K, 0,  32'h8000_0033,  21845, 65535, 0},
        // negative coordinates and t = -3
        '{0, 0, K,  -K, -K, -2*K,  K, -K, -2*K,  -K, K, -2*K,
          -3*K, K, 4*K,  K, 0, 2*K,  32'h0000_0044,  -6*K, K, -2*K},
        // t = -1/3 where the product shift rounds toward minus infinity
        '{0, 0, K,  0, 0, -K,  K, 0, -K,  0, K, -K,
          0, K, 0,  32769, 0, 3*K,  32'hc0de_0055,  -10923, K, -65535},
        // ray parallel to the plane
        '{0, 0, K,  0, 0, 5*K,  K, 0, 5*K,  0, K, 5*K,
          2*K, -3*K, K,  K, K, 0,  32'h0000_0066,  2*K, -3*K, K},
        // oblique plane x + y = 2
        '{K, K, 0,  2*K, 0, 0,  0, 2*K, 0,  K, K, K,
          0, 0, 0,  K, K, K,  32'hffff_ff77,  K, K, K}
    };

    p_hit #(
        .D_BITS          (D_BITS),
        .Q_BITS          (Q_BITS),
        .M_BITS          (M_BITS),
        .FIFO_DEPTH      (FIFO_DEPTH)
    ) i_p_hit (
        .clock           (clock),
        .rst_n           (rst_n),
        .in_wr_en        (in_wr_en),
        .in_full         (in_full),
        .n_in_x          (n_in_x),
        .n_in_y          (n_in_y),
        .n_in_z          (n_in_z),
        .v0_in_x         (v0_in_x),
        .v0_in_y         (v0_in_y),
        .v0_in_z         (v0_in_z),
        .v1_in_x         (v1_in_x),
        .v1_in_y         (v1_in_y),
        .v1_in_z         (v1_in_z),
        .v2_in_x         (v2_in_x),
        .v2_in_y         (v2_in_y),
        .v2_in_z         (v2_in_z),
        .o_x             (o_x),
        .o_y             (o_y),
        .o_z             (o_z),
        .d_x             (d_x),
        .d_y             (d_y),
        .d_z             (d_z),
        .triangle_id_in  (triangle_id_in),
        .out_rd_en       (out_rd_en),
        .out_empty       (out_empty),
        .p_x             (p_x),
        .p_y             (p_y),
        .p_z             (p_z),
        .n_out_x         (n_out_x),
        .n_out_y         (n_out_y),
        .n_out_z         (n_out_z),
        .v0_out_x        (v0_out_x),
        .v0_out_y        (v0_out_y),
        .v0_out_z        (v0_out_z),
        .v1_out_x        (v1_out_x),
        .v1_out_y        (v1_out_y),
        .v1_out_z        (v1_out_z),
        .v2_out_x        (v2_out_x),
        .v2_out_y        (v2_out_y),
        .v2_out_z        (v2_out_z),
        .triangle_id_out (triangle_id_out)
    );

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, %0d of %0d results read", cycles, rd_idx, wr_idx);
            $display("checks: %0d  errors: %0d", check_cnt, err_cnt + 1);
            $display("TEST FAIL");
            $finish;
        end
    end

    // fibonacci lfsr with taps 32 22 2 1, stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // signed field of bits width moved up by shift
    function automatic int rand_fixed(input int bits, input int shift);
        int v;
        v = int'(rand_bits(bits) << (32 - bits)) >>> (32 - bits);
        return v <<< shift;
    endfunction

    function automatic int mul_fx(input int a, input int b);
        longint prod;
        prod = longint'(a) * longint'(b);
        return int'(prod >>> Q_BITS);
    endfunction

    // longint division truncates toward zero
    function automatic int div_fx(input int num, input int den);
        longint q;
        if (den == 0) begin
            return 0;
        end
        q = (longint'(num) <<< Q_BITS) / longint'(den);
        return int'(q);
    endfunction

    function automatic void compute_expected(input int idx);
        int num;
        int den;
        int t;
        num = 0;
        den = 0;
        for (int a = 0; a < 3; a++) begin
            num += mul_fx(rec[idx][a], rec[idx][3+a] - rec[idx][12+a]);
            den += mul_fx(rec[idx][a], rec[idx][15+a]);
        end
        t = div_fx(num, den);
        for (int a = 0; a < 3; a++) begin
            rec[idx][19+a] = rec[idx][12+a] + mul_fx(t, rec[idx][15+a]);
        end
    endfunction

    // integer normal, d in 1/16 steps and points within +-8 keep t * d in range
    function automatic void make_random(input int idx);
        for (int a = 0; a < 3; a++) begin
            rec[idx][a]    = rand_fixed(3, Q_BITS);
            rec[idx][3+a]  = rand_fixed(12, Q_BITS - 8);
            rec[idx][6+a]  = rand_fixed(12, Q_BITS - 8);
            rec[idx][9+a]  = rand_fixed(12, Q_BITS - 8);
            rec[idx][12+a] = rand_fixed(12, Q_BITS - 8);
            rec[idx][15+a] = rand_fixed(7, Q_BITS - 4);
        end
        rec[idx][18] = rand_bits(32);
        compute_expected(idx);
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        check_cnt++;
        if (act_v !== exp_v) begin
            err_cnt++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic check_head();
        int r;
        r = rd_idx;
        check_val("p_x", rec[r][19], p_x);
        check_val("p_y", rec[r][20], p_y);
        check_val("p_z", rec[r][21], p_z);
        check_val("n_out_x", rec[r][0], n_out_x);
        check_val("n_out_y", rec[r][1], n_out_y);
        check_val("n_out_z", rec[r][2], n_out_z);
        check_val("v0_out_x", rec[r][3], v0_out_x);
        check_val("v0_out_y", rec[r][4], v0_out_y);
        check_val("v0_out_z", rec[r][5], v0_out_z);
        check_val("v1_out_x", rec[r][6], v1_out_x);
        check_val("v1_out_y", rec[r][7], v1_out_y);
        check_val("v1_out_z", rec[r][8], v1_out_z);
        check_val("v2_out_x", rec[r][9], v2_out_x);
        check_val("v2_out_y", rec[r][10], v2_out_y);
        check_val("v2_out_z", rec[r][11], v2_out_z);
        check_val("triangle_id_out", rec[r][18], triangle_id_out);
    endtask

    task automatic drive_record(input int idx);
        n_in_x         = rec[idx][0];
        n_in_y         = rec[idx][1];
        n_in_z         = rec[idx][2];
        v0_in_x        = rec[idx][3];
        v0_in_y        = rec[idx][4];
        v0_in_z        = rec[idx][5];
        v1_in_x        = rec[idx][6];
        v1_in_y        = rec[idx][7];
        v1_in_z        = rec[idx][8];
        v2_in_x        = rec[idx][9];
        v2_in_y        = rec[idx][10];
        v2_in_z        = rec[idx][11];
        o_x            = rec[idx][12];
        o_y            = rec[idx][13];
        o_z            = rec[idx][14];
        d_x            = rec[idx][15];
        d_y            = rec[idx][16];
        d_z            = rec[idx][17];
        triangle_id_in = rec[idx][18];
    endtask

    // one falling edge checks and pops the head, then offers the next record
    task automatic step(input bit want_write, input bit want_read, output bit wrote);
        wrote = 1'b0;
        @(negedge clock);
        in_wr_en  = 1'b0;
        out_rd_en = 1'b0;
        if (want_read && !out_empty) begin
            pop_cnt++;
            if (rd_idx >= wr_idx) begin
                err_cnt++;
                $display("%0t a result came out with no record written for it", $time);
            end else begin
                check_head();
                rd_idx++;
            end
            out_rd_en = 1'b1;
        end
        if (want_write && !in_full) begin
            drive_record(wr_idx);
            in_wr_en = 1'b1;
            wr_idx++;
            wrote = 1'b1;
        end
    endtask

    task automatic drain();
        bit w;
        while (rd_idx < wr_idx) begin
            step(1'b0, 1'b1, w);
        end
    endtask

    initial begin
        bit wrote;
        bit want_w;
        bit want_r;
        int burst_n;
        int rnd_end;
        clock     = 1'b0;
        rst_n     = 1'b0;
        in_wr_en  = 1'b0;
        out_rd_en = 1'b0;
        lfsr      = 32'h6d42;
        for (int i = 0; i < N_TAB; i++) begin
            for (int c = 0; c < 22; c++) begin
                rec[i][c] = tab[i][c];
            end
        end
        for (int i = N_TAB; i < MAX_REC; i++) begin
            make_random(i);
        end
        drive_record(0);

        repeat (2) @(negedge clock);
        rst_n = 1'b1;
        @(negedge clock);
        if (in_full !== 1'b0) begin
            err_cnt++;
            $display("%0t in_full did not fall after reset", $time);
        end
        repeat (4) begin
            step(1'b0, 1'b0, wrote);
            if (out_empty !== 1'b1) begin
                err_cnt++;
                $display("%0t out_empty fell before any record was written", $time);
            end
        end

        while (wr_idx < N_TAB) begin
            step(1'b1, 1'b1, wrote);
        end
        drain();

        // burst with the output held off until the queues fill
        burst_n = 0;
        while (!in_full && burst_n < N_BURST) begin
            step(1'b1, 1'b0, wrote);
            if (wrote) begin
                burst_n++;
            end
        end
        if (!in_full) begin
            err_cnt++;
            $display("%0t in_full never rose during the write burst", $time);
        end
        repeat (D_BITS + Q_BITS) step(1'b0, 1'b0, wrote);
        drain();

        rnd_end = wr_idx + N_RAND;
        while (wr_idx < rnd_end) begin
            want_w = rand_bits(1) != 0;
            want_r = rand_bits(2) != 0;
            step(want_w, want_r, wrote);
        end
        drain();

        // any further result would be one too many
        repeat (D_BITS + Q_BITS + 8) step(1'b0, 1'b1, wrote);
        if (pop_cnt != wr_idx) begin
            err_cnt++;
            $display("read %0d results for %0d records written", pop_cnt, wr_idx);
        end

        $display("checks: %0d  errors: %0d  records: %0d", check_cnt, err_cnt, wr_idx);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/p_hit.sv
`timescale 1ns/1ps
`default_nettype none

module p_hit #(
    parameter int D_BITS     = p_hit_pkg::D_BITS_DEF,
    parameter int Q_BITS     = p_hit_pkg::Q_BITS_DEF,
    parameter int M_BITS     = p_hit_pkg::M_BITS_DEF,
    parameter int FIFO_DEPTH = p_hit_pkg::FIFO_DEPTH_DEF
) (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     in_wr_en,
    output logic                     in_full,
    input  logic signed [D_BITS-1:0] n_in_x,
    input  logic signed [D_BITS-1:0] n_in_y,
    input  logic signed [D_BITS-1:0] n_in_z,
    input  logic signed [D_BITS-1:0] v0_in_x,
    input  logic signed [D_BITS-1:0] v0_in_y,
    input  logic signed [D_BITS-1:0] v0_in_z,
    input  logic signed [D_BITS-1:0] v1_in_x,
    input  logic signed [D_BITS-1:0] v1_in_y,
    input  logic signed [D_BITS-1:0] v1_in_z,
    input  logic signed [D_BITS-1:0] v2_in_x,
    input  logic signed [D_BITS-1:0] v2_in_y,
    input  logic signed [D_BITS-1:0] v2_in_z,
    input  logic signed [D_BITS-1:0] o_x,
    input  logic signed [D_BITS-1:0] o_y,
    input  logic signed [D_BITS-1:0] o_z,
    input  logic signed [D_BITS-1:0] d_x,
    input  logic signed [D_BITS-1:0] d_y,
    input  logic signed [D_BITS-1:0] d_z,
    input  logic [M_BITS-1:0]        triangle_id_in,
    input  logic                     out_rd_en,
    output logic                     out_empty,
    output logic signed [D_BITS-1:0] p_x,
    output logic signed [D_BITS-1:0] p_y,
    output logic signed [D_BITS-1:0] p_z,
    output logic signed [D_BITS-1:0] n_out_x,
    output logic signed [D_BITS-1:0] n_out_y,
    output logic signed [D_BITS-1:0] n_out_z,
    output logic signed [D_BITS-1:0] v0_out_x,
    output logic signed [D_BITS-1:0] v0_out_y,
    output logic signed [D_BITS-1:0] v0_out_z,
    output logic signed [D_BITS-1:0] v1_out_x,
    output logic signed [D_BITS-1:0] v1_out_y,
    output logic signed [D_BITS-1:0] v1_out_z,
    output logic signed [D_BITS-1:0] v2_out_x,
    output logic signed [D_BITS-1:0] v2_out_y,
    output logic signed [D_BITS-1:0] v2_out_z,
    output logic [M_BITS-1:0]        triangle_id_out
);

    import p_hit_pkg::*;

    // lane counts: n, v0, o, d / o, d / v0, v1, v2, n and the id
    localparam int CALC_LANES = 4 * NUM_AXES;
    localparam int RAY_LANES  = 2 * NUM_AXES;
    localparam int PASS_LANES = 4 * NUM_AXES + 1;

    logic [CALC_LANES*D_BITS-1:0] calc_din;
    logic [CALC_LANES*D_BITS-1:0] calc_dout;
    logic [RAY_LANES*D_BITS-1:0]  ray_din;
    logic [RAY_LANES*D_BITS-1:0]  ray_dout;
    logic [PASS_LANES*D_BITS-1:0] pass_din;
    logic [PASS_LANES*D_BITS-1:0] pass_dout;
    logic                         calc_full;
    logic                         calc_empty;
    logic                         calc_rd_en;
    logic                         ray_full;
    logic                         ray_empty;
    logic                         pass_full;
    logic                         pass_empty;
    logic signed [D_BITS-1:0]     t;
    logic                         t_empty;
    logic                         sa_in_empty;
    logic                         sa_rd_en;
    logic                         sa_empty;
    logic                         out_pop;

    // lane 0 sits in the low bits
    assign calc_din = {d_z, d_y, d_x, o_z, o_y, o_x,
                       v0_in_z, v0_in_y, v0_in_x, n_in_z, n_in_y, n_in_x};
    assign ray_din  = {d_z, d_y, d_x, o_z, o_y, o_x};
    assign pass_din = {D_BITS'(triangle_id_in), n_in_z, n_in_y, n_in_x,
                       v2_in_z, v2_in_y, v2_in_x, v1_in_z, v1_in_y, v1_in_x,
                       v0_in_z, v0_in_y, v0_in_x};

    assign in_full     = calc_full || ray_full || pass_full;
    assign sa_in_empty = t_empty || ray_empty;
    assign out_empty   = sa_empty || pass_empty;
    assign out_pop     = out_rd_en && !out_empty;

    fifo_array #(
        .WIDTH      (D_BITS),
        .ARRAY_SIZE (CALC_LANES),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) calc_fifo (
        .clock      (clock),
        .rst_n      (rst_n),
        .wr_en      (in_wr_en),
        .din        (calc_din),
        .full       (calc_full),
        .rd_en      (calc_rd_en),
        .dout       (calc_dout),
        .empty      (calc_empty)
    );

    fifo_array #(
        .WIDTH      (D_BITS),
        .ARRAY_SIZE (RAY_LANES),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) ray_fifo (
        .clock      (clock),
        .rst_n      (rst_n),
        .wr_en      (in_wr_en),
        .din        (ray_din),
        .full       (ray_full),
        .rd_en      (sa_rd_en),
        .dout       (ray_dout),
        .empty      (ray_empty)
    );

    fifo_array #(
        .WIDTH      (D_BITS),
        .ARRAY_SIZE (PASS_LANES),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) pass_fifo (
        .clock      (clock),
        .rst_n      (rst_n),
        .wr_en      (in_wr_en),
        .din        (pass_din),
        .full       (pass_full),
        .rd_en      (out_pop),
        .dout       (pass_dout),
        .empty      (pass_empty)
    );

    p_hit_div #(
        .D_BITS     (D_BITS),
        .Q_BITS     (Q_BITS)
    ) u_p_hit_div (
        .clock      (clock),
        .rst_n      (rst_n),
        .n_x        (calc_dout[0*D_BITS +: D_BITS]),
        .n_y        (calc_dout[1*D_BITS +: D_BITS]),
        .n_z        (calc_dout[2*D_BITS +: D_BITS]),
        .v0_x       (calc_dout[3*D_BITS +: D_BITS]),
        .v0_y       (calc_dout[4*D_BITS +: D_BITS]),
        .v0_z       (calc_dout[5*D_BITS +: D_BITS]),
        .o_x        (calc_dout[6*D_BITS +: D_BITS]),
        .o_y        (calc_dout[7*D_BITS +: D_BITS]),
        .o_z        (calc_dout[8*D_BITS +: D_BITS]),
        .d_x        (calc_dout[9*D_BITS +: D_BITS]),
        .d_y        (calc_dout[10*D_BITS +: D_BITS]),
        .d_z        (calc_dout[11*D_BITS +: D_BITS]),
        .in_empty   (calc_empty),
        .in_rd_en   (calc_rd_en),
        .t          (t),
        .t_empty    (t_empty),
        .t_rd_en    (sa_rd_en)
    );

    // one strobe pops t and the matching ray together
    p_hit_scale_add #(
        .D_BITS     (D_BITS),
        .Q_BITS     (Q_BITS)
    ) u_p_hit_scale_add (
        .clock      (clock),
        .rst_n      (rst_n),
        .t          (t),
        .o_x        (ray_dout[0*D_BITS +: D_BITS]),
        .o_y        (ray_dout[1*D_BITS +: D_BITS]),
        .o_z        (ray_dout[2*D_BITS +: D_BITS]),
        .d_x        (ray_dout[3*D_BITS +: D_BITS]),
        .d_y        (ray_dout[4*D_BITS +: D_BITS]),
        .d_z        (ray_dout[5*D_BITS +: D_BITS]),
        .in_empty   (sa_in_empty),
        .in_rd_en   (sa_rd_en),
        .p_x        (p_x),
        .p_y        (p_y),
        .p_z        (p_z),
        .out_empty  (sa_empty),
        .out_rd_en  (out_pop)
    );

    assign v0_out_x = pass_dout[0*D_BITS +: D_BITS];
    assign v0_out_y = pass_dout[1*D_BITS +: D_BITS];
    assign v0_out_z = pass_dout[2*D_BITS +: D_BITS];
    assign v1_out_x = pass_dout[3*D_BITS +: D_BITS];
    assign v1_out_y = pass_dout[4*D_BITS +: D_BITS];
    assign v1_out_z = pass_dout[5*D_BITS +: D_BITS];
    assign v2_out_x = pass_dout[6*D_BITS +: D_BITS];
    assign v2_out_y = pass_dout[7*D_BITS +: D_BITS];
    assign v2_out_z = pass_dout[8*D_BITS +: D_BITS];
    assign n_out_x  = pass_dout[9*D_BITS +: D_BITS];
    assign n_out_y  = pass_dout[10*D_BITS +: D_BITS];
    assign n_out_z  = pass_dout[11*D_BITS +: D_BITS];

    // id rides zero-extended in the last lane
    assign triangle_id_out = pass_dout[12*D_BITS +: M_BITS];

    assert property (@(posedge clock) disable iff (!rst_n) in_wr_en |-> !in_full)
        else $error("p_hit: producer wrote while in_full was high");

endmodule

`default_nettype wire

// File: rtl/p_hit_scale_add.sv
`timescale 1ns/1ps
`default_nettype none

module p_hit_scale_add #(
    parameter int D_BITS = p_hit_pkg::D_BITS_DEF,
    parameter int Q_BITS = p_hit_pkg::Q_BITS_DEF
) (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic signed [D_BITS-1:0] t,
    input  logic signed [D_BITS-1:0] o_x,
    input  logic signed [D_BITS-1:0] o_y,
    input  logic signed [D_BITS-1:0] o_z,
    input  logic signed [D_BITS-1:0] d_x,
    input  logic signed [D_BITS-1:0] d_y,
    input  logic signed [D_BITS-1:0] d_z,
    input  logic                     in_empty,
    output logic                     in_rd_en,
    output logic signed [D_BITS-1:0] p_x,
    output logic signed [D_BITS-1:0] p_y,
    output logic signed [D_BITS-1:0] p_z,
    output logic                     out_empty,
    input  logic                     out_rd_en
);

    logic signed [2*D_BITS-1:0] prod_x;
    logic signed [2*D_BITS-1:0] prod_y;
    logic signed [2*D_BITS-1:0] prod_z;

    // full width t * d with the fraction dropped at the add
    assign prod_x = t * d_x;
    assign prod_y = t * d_y;
    assign prod_z = t * d_z;

    // take a new input when the stage is free or drains this cycle
    assign in_rd_en = !in_empty && (out_empty || out_rd_en);

    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            p_x <= o_x + prod_x[Q_BITS +: D_BITS];
            p_y <= o_y + prod_y[Q_BITS +: D_BITS];
            p_z <= o_z + prod_z[Q_BITS +: D_BITS];
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            out_empty <= 1'b1;
        end else if (in_rd_en) begin
            out_empty <= 1'b0;
        end else if (out_rd_en) begin
            out_empty <= 1'b1;
        end
    end

    assert property (@(posedge clock) disable iff (!rst_n) out_rd_en |-> !out_empty)
        else $error("p_hit_scale_add: pop while the output stage is empty");

endmodule

`default_nettype wire

// File: rtl/p_hit_div.sv
`timescale 1ns/1ps
`default_nettype none

module p_hit_div #(
    parameter int D_BITS = p_hit_pkg::D_BITS_DEF,
    parameter int Q_BITS = p_hit_pkg::Q_BITS_DEF
) (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic signed [D_BITS-1:0] n_x,
    input  logic signed [D_BITS-1:0] n_y,
    input  logic signed [D_BITS-1:0] n_z,
    input  logic signed [D_BITS-1:0] v0_x,
    input  logic signed [D_BITS-1:0] v0_y,
    input  logic signed [D_BITS-1:0] v0_z,
    input  logic signed [D_BITS-1:0] o_x,
    input  logic signed [D_BITS-1:0] o_y,
    input  logic signed [D_BITS-1:0] o_z,
    input  logic signed [D_BITS-1:0] d_x,
    input  logic signed [D_BITS-1:0] d_y,
    input  logic signed [D_BITS-1:0] d_z,
    input  logic                     in_empty,
    output logic                     in_rd_en,
    output logic signed [D_BITS-1:0] t,
    output logic                     t_empty,
    input  logic                     t_rd_en
);

    // dividend is |num| << Q_BITS, one quotient bit per cycle
    localparam int N_BITS = D_BITS + Q_BITS;
    localparam int CNT_W  = $clog2(N_BITS);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_LOAD = 2'd1;
    localparam logic [1:0] S_DIV  = 2'd2;

    logic [1:0]               state;
    logic                     busy;
    logic [CNT_W-1:0]         cnt;
    logic signed [D_BITS-1:0] num_c;
    logic signed [D_BITS-1:0] den_c;
    logic signed [D_BITS-1:0] num_q;
    logic signed [D_BITS-1:0] den_q;
    logic [D_BITS-1:0]        num_mag;
    logic [D_BITS-1:0]        den_mag;
    logic [D_BITS-1:0]        div_mag;
    logic                     neg;
    logic [D_BITS-1:0]        rem;
    logic [D_BITS-1:0]        rem_next;
    logic [D_BITS:0]          rem_shift;
    logic                     q_bit;
    logic [N_BITS-1:0]        quo;
    logic [N_BITS-1:0]        quo_next;

    // fixed point product, truncated by the arithmetic shift
    function automatic logic signed [D_BITS-1:0] mul_q(
        input logic signed [D_BITS-1:0] a,
        input logic signed [D_BITS-1:0] b
    );
        logic signed [2*D_BITS-1:0] prod;
        prod = a * b;
        return prod[Q_BITS +: D_BITS];
    endfunction

    // n . (v0 - o) and n . d straight off the queue head
    assign num_c = mul_q(n_x, v0_x - o_x) + mul_q(n_y, v0_y - o_y) + mul_q(n_z, v0_z - o_z);
    assign den_c = mul_q(n_x, d_x) + mul_q(n_y, d_y) + mul_q(n_z, d_z);

    assign num_mag = num_q[D_BITS-1] ? $unsigned(-num_q) : $unsigned(num_q);
    assign den_mag = den_q[D_BITS-1] ? $unsigned(-den_q) : $unsigned(den_q);

    // one restoring step
    assign rem_shift = {rem, quo[N_BITS-1]};
    assign q_bit     = (rem_shift >= {1'b0, div_mag});
    assign rem_next  = q_bit ? D_BITS'(rem_shift - {1'b0, div_mag}) : rem_shift[D_BITS-1:0];
    assign quo_next  = {quo[N_BITS-2:0], q_bit};

    assign busy = (state != S_IDLE);

    // a t being taken this cycle frees the slot for the next record
    assign in_rd_en = !busy && (t_empty || t_rd_en) && !in_empty;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            cnt     <= '0;
            t_empty <= 1'b1;
        end else begin
            if (t_rd_en) begin
                t_empty <= 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (in_rd_en) begin
                        state <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    cnt <= CNT_W'(N_BITS - 1);
                    // parallel ray, no division
                    if (den_q == '0) begin
                        state   <= S_IDLE;
                        t_empty <= 1'b0;
                    end else begin
                        state <= S_DIV;
                    end
                end
                S_DIV: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == '0) begin
                        state   <= S_IDLE;
                        t_empty <= 1'b0;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            num_q <= num_c;
            den_q <= den_c;
        end
        case (state)
            S_LOAD: begin
                div_mag <= den_mag;
                rem     <= '0;
                quo     <= {num_mag, {Q_BITS{1'b0}}};
                neg     <= num_q[D_BITS-1] ^ den_q[D_BITS-1];
                if (den_q == '0) begin
                    t <= '0;
                end
            end
            S_DIV: begin
                rem <= rem_next;
                quo <= quo_next;
                // sign goes back on with the last quotient bit
                if (cnt == '0) begin
                    t <= neg ? -quo_next[D_BITS-1:0] : quo_next[D_BITS-1:0];
                end
            end
            default: begin
            end
        endcase
    end

    // t is taken before work on the next record starts
    assert property (@(posedge clock) disable iff (!rst_n) busy |-> t_empty)
        else $error("p_hit_div: divider busy while t still waiting");

endmodule

`default_nettype wire

// File: rtl/fifo_array.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_array #(
    parameter int WIDTH      = p_hit_pkg::D_BITS_DEF,
    parameter int ARRAY_SIZE = p_hit_pkg::NUM_AXES,
    parameter int FIFO_DEPTH = p_hit_pkg::FIFO_DEPTH_DEF
) (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        wr_en,
    input  logic [ARRAY_SIZE*WIDTH-1:0] din,
    output logic                        full,
    input  logic                        rd_en,
    output logic [ARRAY_SIZE*WIDTH-1:0] dout,
    output logic                        empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [ARRAY_SIZE*WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    logic [CNT_W-1:0]            count;
    logic [CNT_W-1:0]            count_next;
    logic                        do_wr;
    logic                        do_rd;

    // wrap at FIFO_DEPTH, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // head entry is visible without a read
    assign dout = mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (do_wr && !do_rd) begin
            count_next = count + 1'b1;
        end else if (do_rd && !do_wr) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    // flags are registered from the next count, full held high in reset
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b1;
            empty  <= 1'b1;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count_next;
            full  <= (count_next == CNT_W'(FIFO_DEPTH));
            empty <= (count_next == '0);
        end
    end

    assert property (@(posedge clock) disable iff (!rst_n) wr_en |-> !full)
        else $error("fifo_array: write while full, record dropped");

    assert property (@(posedge clock) disable iff (!rst_n) rd_en |-> !empty)
        else $error("fifo_array: read while empty");

endmodule

`default_nettype wire

// File: rtl/p_hit_pkg.sv
`default_nettype none

package p_hit_pkg;

    // coordinates per vector (x, y, z)
    localparam int NUM_AXES = 3;

    // signed fixed point word, two's complement
    localparam int D_BITS_DEF = 32;

    // fraction bits of every coordinate and of t
    localparam int Q_BITS_DEF = 16;

    // triangle id width, carried zero-extended in a data lane
    localparam int M_BITS_DEF = 32;

    // entries per queue
    localparam int FIFO_DEPTH_DEF = 16;

endpackage

`default_nettype wire
